// File: filelist.f
design/pmp_pkg.sv
design/pmp_csr_axil.sv
design/pmp_regfile.sv
design/pmp_matcher.sv
design/pmp_checker.sv
design/pmp_fault_report.sv
design/pmp_top.sv
verif/pmp_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the PMP testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f filelist.f --top-module pmp_tb \
    -Mdir obj_dir -o pmp_sim; then
  echo "build failed"
  exit 1
fi

if ! ./obj_dir/pmp_sim > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
exit 1

// File: verif/pmp_tb.sv
// Clock, reset, AXI4-Lite and access drivers, shadow model, checks and summary for the PMP unit
`timescale 1ns/1ns

module pmp_tb;

  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 1000;
  localparam int CLK_PERIOD      = 4;
  localparam logic [1:0] OKAY    = 2'b00;
  localparam logic [1:0] SLVERR  = 2'b10;
  localparam int MODE_U    = 0;
  localparam int MODE_M    = 1;
  localparam int MODE_MPRV = 2;  // M mode, MPRV set, MPP=U
  localparam int MODE_ANY  = 3;

  logic CLK;
  logic nRST;
  logic [31:0] i_awaddr, i_wdata, i_araddr, o_rdata;
  logic [3:0]  i_wstrb;
  logic [1:0]  o_bresp, o_rresp;
  logic i_awvalid, o_awready, i_wvalid, o_wready, o_bvalid, i_bready;
  logic i_arvalid, o_arready, o_rvalid, i_rready;
  pmp_pkg::pmp_access_t i_access;
  pmp_pkg::pmp_fault_t  o_fault;
  pmp_pkg::pmp_fault_t  exp_q;  // Expected result of the request sampled at the last edge

  pmp_pkg::pmp_cfg_t  sh_cfg  [pmp_pkg::PMP_ENTRIES];  // Shadow registers
  pmp_pkg::pmp_addr_t sh_addr [pmp_pkg::PMP_ENTRIES];

  logic [31:0] seed = 32'd13803;
  int err_count, test_num, tests_failed, test_start_errs;
  string test_name;

  pmp_top #(.PMP_GRAN(0)) pmp_top_inst (
    .CLK(CLK), .nRST(nRST),
    .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
    .i_wdata(i_wdata), .i_wstrb(i_wstrb), .i_wvalid(i_wvalid), .o_wready(o_wready),
    .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
    .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
    .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
    .i_access(i_access), .o_fault(o_fault)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  function automatic logic [31:0] rand32();
    seed = seed * 32'd1664525 + 32'd1013904223;  // LCG step
    return seed;
  endfunction

  function automatic pmp_pkg::priv_e pick_priv(input logic [1:0] r);
    case (r)
      2'd0:    return pmp_pkg::U;
      2'd1:    return pmp_pkg::S;
      default: return pmp_pkg::M;
    endcase
  endfunction

  // Applies a bus write to the shadow copy and returns the expected BRESP
  function automatic logic [1:0] model_write(input logic [31:0] a, input pmp_pkg::pmp_word_t d,
                                             input logic [3:0] strb);
    logic [3:0] idx;
    logic [3:0] ent;
    logic       locked;
    pmp_pkg::pmp_cfg_t nb;
    if (strb != 4'hF) return SLVERR;
    if (a < 32'h10 && a[1:0] == 2'b00) begin
      for (int b = 0; b < 4; b++) begin
        ent = {a[3:2], b[1:0]};
        nb = pmp_pkg::pmp_cfg_t'(d[8*b +: 8]);
        nb.reserved = 2'b00;
        if (!nb.r) nb.w = 1'b0;
        if (!sh_cfg[ent].lock) sh_cfg[ent] = nb;
      end
      return OKAY;
    end
    if (a >= 32'h40 && a < 32'h80 && a[1:0] == 2'b00) begin
      idx = a[5:2];
      locked = sh_cfg[idx].lock;
      if (idx != 4'd15 && sh_cfg[idx + 4'd1].lock && sh_cfg[idx + 4'd1].amode == pmp_pkg::TOR)
        locked = 1'b1;  // Base of a locked TOR range
      if (!locked) sh_addr[idx] = d;
      return OKAY;
    end
    return SLVERR;
  endfunction

  function automatic pmp_pkg::pmp_word_t model_read(input logic [31:0] a,
                                                    output logic [1:0] resp);
    resp = OKAY;
    if (a < 32'h10 && a[1:0] == 2'b00)
      return {sh_cfg[{a[3:2], 2'd3}], sh_cfg[{a[3:2], 2'd2}],
              sh_cfg[{a[3:2], 2'd1}], sh_cfg[{a[3:2], 2'd0}]};
    if (a >= 32'h40 && a < 32'h80 && a[1:0] == 2'b00) return sh_addr[a[5:2]];
    resp = SLVERR;
    return '0;
  endfunction

  // Byte address ranges in a 64-bit space, so NAPOT and TOR bounds never wrap
  function automatic logic entry_hit(input int e, input logic [31:0] a);
    logic [63:0] ba;
    logic [63:0] lo;
    logic [63:0] size;
    int k;
    ba = {32'd0, a[31:2], 2'b00};
    case (sh_cfg[e].amode)
      pmp_pkg::TOR: begin
        lo = (e == 0) ? 64'd0 : {32'd0, sh_addr[e-1]} << 2;
        return ba >= lo && ba < ({32'd0, sh_addr[e]} << 2);
      end
      pmp_pkg::NA4: begin
        lo = {32'd0, sh_addr[e]} << 2;
        return ba >= lo && ba < lo + 64'd4;
      end
      pmp_pkg::NAPOT: begin
        k = 0;
        while (k < 32 && sh_addr[e][k]) k++;
        size = 64'd8 << k;
        lo = ({32'd0, sh_addr[e]} << 2) & ~(size - 64'd1);
        return ba >= lo && ba < lo + size;
      end
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic side_fault(input logic [31:0] a, input logic rd, input logic wr,
                                      input logic is_fetch, input pmp_pkg::priv_e p);
    logic found;
    logic denied;
    pmp_pkg::pmp_cfg_t c;
    if (!rd && !wr) return 1'b0;
    found = 1'b0;
    c = '0;
    for (int e = 0; e < pmp_pkg::PMP_ENTRIES; e++) begin
      if (!found && entry_hit(e, a)) begin
        found = 1'b1;
        c = sh_cfg[e];
      end
    end
    denied = (rd && !(is_fetch ? c.x : c.r)) || (wr && !c.w);
    if (p == pmp_pkg::M) return found && c.lock && denied;
    return !found || denied;
  endfunction

  function automatic pmp_pkg::pmp_fault_t ref_fault(input pmp_pkg::pmp_access_t acc);
    pmp_pkg::pmp_fault_t f;
    logic d_bad;
    logic i_bad;
    f = '0;
    if (!acc.valid) return f;
    f.valid = 1'b1;
    d_bad = side_fault(acc.daddr, acc.ren, acc.wen, 1'b0, acc.mprv ? acc.mpp : acc.priv);
    i_bad = side_fault(acc.iaddr, acc.xen, 1'b0, 1'b1, acc.priv);
    if (d_bad) begin
      f.s_fault = acc.wen;
      f.l_fault = acc.ren;
    end else begin
      f.i_fault = acc.xen && i_bad;
    end
    return f;
  endfunction

  task automatic fail_note(input string msg);
    $display("error at %0t: %s", $time, msg);
    err_count++;
  endtask

  task automatic check_word(input string name, input pmp_pkg::pmp_word_t got,
                            input pmp_pkg::pmp_word_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_fault(input string name, input pmp_pkg::pmp_fault_t got,
                             input pmp_pkg::pmp_fault_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  // Results checked half a cycle after the edge that registers them
  always @(posedge CLK) exp_q <= ref_fault(i_access);
  always @(negedge CLK) if (nRST) check_fault("o_fault", o_fault, exp_q);

  task automatic apply_reset();
    nRST = 1'b0;
    {i_awvalid, i_wvalid, i_arvalid, i_bready, i_rready} = '0;
    i_awaddr = '0;
    i_wdata  = '0;
    i_wstrb  = '0;
    i_araddr = '0;
    i_access = '0;
    for (int e = 0; e < pmp_pkg::PMP_ENTRIES; e++) begin
      sh_cfg[e]  = '0;
      sh_addr[e] = '0;
    end
    repeat (5) @(posedge CLK);
    #1 nRST = 1'b1;
  endtask

  // Entered 1 ns after an edge, leaves 1 ns after the edge that takes the B response
  task automatic bus_write(input logic [31:0] a, input pmp_pkg::pmp_word_t d,
                           input logic [3:0] strb, input int hold);
    logic [1:0] exp_resp;
    logic [1:0] first;
    int n;
    {i_awaddr, i_wdata, i_wstrb, i_awvalid, i_wvalid} = {a, d, strb, 2'b11};
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (!(o_awready && o_wready) && n < 50);
    if (!(o_awready && o_wready)) fail_note("write address and data were never accepted");
    @(posedge CLK);
    #1 {i_awvalid, i_wvalid} = 2'b00;
    i_bready = (hold == 0);
    exp_resp = model_write(a, d, strb);  // Registers update on the acceptance edge
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (!o_bvalid && n < 50);
    if (!o_bvalid) fail_note("write response never became valid");
    first = o_bresp;
    repeat (hold) begin
      @(negedge CLK);
      if (!o_bvalid) fail_note("BVALID dropped while BREADY was low");
      check_resp("o_bresp", o_bresp, first);
    end
    if (hold > 0) begin
      @(posedge CLK);
      #1 i_bready = 1'b1;
    end
    @(posedge CLK);
    #1 i_bready = 1'b0;
    check_resp("o_bresp", first, exp_resp);
  endtask

  task automatic bus_read(input logic [31:0] a, input int hold);
    pmp_pkg::pmp_word_t exp_data;
    pmp_pkg::pmp_word_t first_data;
    logic [1:0] exp_resp;
    logic [1:0] first;
    int n;
    exp_data = model_read(a, exp_resp);
    {i_araddr, i_arvalid} = {a, 1'b1};
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (!o_arready && n < 50);
    if (!o_arready) fail_note("read address was never accepted");
    @(posedge CLK);
    #1 i_arvalid = 1'b0;
    i_rready = (hold == 0);
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (!o_rvalid && n < 50);
    if (!o_rvalid) fail_note("read response never became valid");
    {first, first_data} = {o_rresp, o_rdata};
    repeat (hold) begin
      @(negedge CLK);
      if (!o_rvalid) fail_note("RVALID dropped while RREADY was low");
      check_resp("o_rresp", o_rresp, first);
      check_word("o_rdata", o_rdata, first_data);
    end
    if (hold > 0) begin
      @(posedge CLK);
      #1 i_rready = 1'b1;
    end
    @(posedge CLK);
    #1 i_rready = 1'b0;
    check_resp("o_rresp", first, exp_resp);
    check_word("o_rdata", first_data, exp_data);
  endtask

  task automatic read_all_regs();
    for (int i = 0; i < 4; i++) bus_read(pmp_pkg::CFG_BASE + 32'(4 * i), 0);
    for (int i = 0; i < 16; i++) bus_read(pmp_pkg::ADDR_BASE + 32'(4 * i), 0);
  endtask

  task automatic drive_access(input pmp_pkg::pmp_access_t a);
    i_access = a;
    @(posedge CLK);
    #1;
  endtask

  task automatic run_accesses(input int n, input int mode, input logic [31:0] mask);
    pmp_pkg::pmp_access_t a;
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = rand32();
      a.valid = 1'b1;
      a.daddr = rand32() & mask;
      a.iaddr = rand32() & mask;
      {a.xen, a.wen, a.ren} = r[2:0];
      a.priv = (mode == MODE_ANY) ? pick_priv(r[4:3]) :
               (mode == MODE_U) ? pmp_pkg::U : pmp_pkg::M;
      a.mprv = (mode == MODE_ANY) ? r[5] : (mode == MODE_MPRV);
      a.mpp  = (mode == MODE_MPRV) ? pmp_pkg::U : pick_priv(r[7:6]);
      drive_access(a);
    end
    drive_access('0);  // Lets the last result reach its check
  endtask

  // TOR 0..0x3FF, NA4 at 0x800, NAPOT 0x10000..0x11FFF, wide NAPOT 0..0x1FFFF
  task automatic setup_regions();
    bus_write(pmp_pkg::ADDR_BASE + 32'h0, 32'h0000_0100, 4'hF, 0);
    bus_write(pmp_pkg::ADDR_BASE + 32'h4, 32'h0000_0200, 4'hF, 0);
    bus_write(pmp_pkg::ADDR_BASE + 32'h8, 32'h0000_43FF, 4'hF, 0);
    bus_write(pmp_pkg::ADDR_BASE + 32'hC, 32'h0000_3FFF, 4'hF, 0);
    bus_write(pmp_pkg::CFG_BASE, 32'h191C_130F, 4'hF, 0);
  endtask

  task automatic begin_test(input string name);
    test_num++;
    test_name = name;
    test_start_errs = err_count;
    apply_reset();
  endtask

  task automatic end_test();
    if (err_count == test_start_errs) begin
      $display("test %0d %s: ok", test_num, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", test_num, test_name, err_count - test_start_errs);
    end
  endtask

  initial begin
    nRST = 1'b0;
    {i_awvalid, i_wvalid, i_arvalid, i_bready, i_rready} = '0;
    {i_awaddr, i_wdata, i_araddr, i_wstrb} = '0;
    i_access = '0;
    {err_count, test_num, tests_failed, test_start_errs} = '0;

    begin_test("config readback");
    for (int i = 0; i < 4; i++)
      bus_write(pmp_pkg::CFG_BASE + 32'(4 * i), rand32() & 32'h7F7F_7F7F, 4'hF, 0);
    for (int i = 0; i < 16; i++) bus_write(pmp_pkg::ADDR_BASE + 32'(4 * i), rand32(), 4'hF, 0);
    read_all_regs();
    end_test();

    begin_test("locking");
    bus_write(pmp_pkg::ADDR_BASE + 32'h10, 32'h0000_0111, 4'hF, 0);
    bus_write(pmp_pkg::ADDR_BASE + 32'h14, 32'h0000_0222, 4'hF, 0);
    bus_write(pmp_pkg::CFG_BASE + 32'h4, 32'h0000_8900, 4'hF, 0);  // Entry 5 locked TOR
    bus_write(pmp_pkg::CFG_BASE + 32'h8, 32'h0000_9B00, 4'hF, 0);  // Entry 9 locked NAPOT
    bus_write(pmp_pkg::CFG_BASE + 32'h4, 32'h0F0F_0F0F, 4'hF, 0);
    for (int i = 0; i < 16; i++) bus_write(pmp_pkg::ADDR_BASE + 32'(4 * i), rand32(), 4'hF, 0);
    read_all_regs();
    end_test();

    begin_test("user mode regions");
    setup_regions();
    run_accesses(300, MODE_U, 32'h0003_FFFF);
    end_test();

    begin_test("machine mode");
    bus_write(pmp_pkg::ADDR_BASE, 32'h0000_03FF, 4'hF, 0);
    bus_write(pmp_pkg::ADDR_BASE + 32'h4, 32'h0000_1000, 4'hF, 0);
    bus_write(pmp_pkg::CFG_BASE, 32'h0000_0899, 4'hF, 0);  // Locked R-only NAPOT, open TOR
    run_accesses(150, MODE_M, 32'h0000_7FFF);
    run_accesses(150, MODE_MPRV, 32'h0000_7FFF);
    end_test();

    begin_test("precedence and pipelining");
    drive_access('{valid: 1'b1, daddr: 32'h100, iaddr: 32'h200, ren: 1'b1, wen: 1'b0,
                   xen: 1'b1, priv: pmp_pkg::U, mprv: 1'b0, mpp: pmp_pkg::U});
    drive_access('0);
    setup_regions();
    run_accesses(100, MODE_ANY, 32'h0003_FFFF);
    end_test();

    begin_test("bus errors and back-pressure");
    bus_write(pmp_pkg::ADDR_BASE, 32'h0000_1234, 4'hF, 0);
    bus_write(32'h0000_0020, 32'hFFFF_FFFF, 4'hF, 0);
    bus_write(32'h0000_0080, 32'hFFFF_FFFF, 4'hF, 0);
    bus_write(32'h0000_0042, 32'hFFFF_FFFF, 4'hF, 0);
    bus_write(pmp_pkg::CFG_BASE, 32'h0F0F_0F0F, 4'h7, 0);  // Partial strobe
    bus_write(pmp_pkg::ADDR_BASE, 32'h0000_5678, 4'h0, 2);
    bus_read(32'h0000_0030, 0);
    bus_read(32'h0000_0084, 3);
    bus_write(pmp_pkg::ADDR_BASE + 32'h4, rand32(), 4'hF, 3);
    bus_read(pmp_pkg::ADDR_BASE + 32'h4, 4);
    read_all_regs();
    end_test();

    $display("summary: %0d tests, %0d failed, %0d errors", test_num, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("timeout: the tests did not finish in %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: design/pmp_top.sv
// PMP top level: AXI4-Lite config port, register file, data and fetch checkers, fault report
`timescale 1ns/1ns

module pmp_top #(
  parameter int PMP_GRAN = 0
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic [31:0]          i_awaddr,
  input  logic                 i_awvalid,
  output logic                 o_awready,
  input  logic [31:0]          i_wdata,
  input  logic [3:0]           i_wstrb,
  input  logic                 i_wvalid,
  output logic                 o_wready,
  output logic [1:0]           o_bresp,
  output logic                 o_bvalid,
  input  logic                 i_bready,
  input  logic [31:0]          i_araddr,
  input  logic                 i_arvalid,
  output logic                 o_arready,
  output logic [31:0]          o_rdata,
  output logic [1:0]           o_rresp,
  output logic                 o_rvalid,
  input  logic                 i_rready,
  input  pmp_pkg::pmp_access_t i_access,
  output pmp_pkg::pmp_fault_t  o_fault
);

  pmp_pkg::pmp_csr_req_t csr_req;
  pmp_pkg::pmp_csr_rsp_t csr_rsp;
  pmp_pkg::pmp_cfg_t  [pmp_pkg::PMP_ENTRIES-1:0] cfg;
  pmp_pkg::pmp_addr_t [pmp_pkg::PMP_ENTRIES-1:0] addr;
  logic d_fault;
  logic i_fault;

  pmp_csr_axil csr_axil_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .i_awaddr  (i_awaddr),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .o_bresp   (o_bresp),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .i_araddr  (i_araddr),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_csr_req (csr_req),
    .i_csr_rsp (csr_rsp)
  );

  pmp_regfile #(.PMP_GRAN(PMP_GRAN)) regfile_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .i_csr_req (csr_req),
    .o_csr_rsp (csr_rsp),
    .o_cfg     (cfg),
    .o_addr    (addr)
  );

  // Data port, MPRV applies
  pmp_checker #(.IS_DATA(1'b1), .PMP_GRAN(PMP_GRAN)) d_checker_inst (
    .i_addr     (i_access.daddr),
    .i_rd       (i_access.ren),
    .i_wr       (i_access.wen),
    .i_cfg      (cfg),
    .i_pmp_addr (addr),
    .i_priv     (i_access.priv),
    .i_mprv     (i_access.mprv),
    .i_mpp      (i_access.mpp),
    .o_fault    (d_fault)
  );

  // Fetch port, xen rides on the read input
  pmp_checker #(.IS_DATA(1'b0), .PMP_GRAN(PMP_GRAN)) i_checker_inst (
    .i_addr     (i_access.iaddr),
    .i_rd       (i_access.xen),
    .i_wr       (1'b0),
    .i_cfg      (cfg),
    .i_pmp_addr (addr),
    .i_priv     (i_access.priv),
    .i_mprv     (i_access.mprv),
    .i_mpp      (i_access.mpp),
    .o_fault    (i_fault)
  );

  pmp_fault_report fault_report_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .i_valid   (i_access.valid),
    .i_ren     (i_access.ren),
    .i_wen     (i_access.wen),
    .i_xen     (i_access.xen),
    .i_d_fault (d_fault),
    .i_i_fault (i_fault),
    .o_fault   (o_fault)
  );

endmodule

// File: design/pmp_fault_report.sv
// PMP fault report: data over instruction precedence and the registered fault result
`timescale 1ns/1ns

module pmp_fault_report (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                i_valid,
  input  logic                i_ren,
  input  logic                i_wen,
  input  logic                i_xen,
  input  logic                i_d_fault,
  input  logic                i_i_fault,
  output pmp_pkg::pmp_fault_t o_fault
);

  pmp_pkg::pmp_fault_t fault_d;

  always_comb begin
    fault_d       = '0;
    fault_d.valid = i_valid;
    if (i_valid && i_d_fault) begin
      fault_d.s_fault = i_wen;
      fault_d.l_fault = i_ren;
    end else if (i_valid) begin
      fault_d.i_fault = i_xen && i_i_fault;  // Only when the data side is clean
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) o_fault <= '0;
    else o_fault <= fault_d;
  end

  a_one_kind: assert property (@(posedge CLK) disable iff (!nRST)
    o_fault.valid |-> !(o_fault.s_fault && o_fault.i_fault));

endmodule

// File: design/pmp_checker.sv
// PMP access checker: sixteen matchers, lowest-entry priority and privilege rules for one port
`timescale 1ns/1ns

module pmp_checker #(
  parameter bit IS_DATA  = 1'b1,
  parameter int PMP_GRAN = 0
) (
  input  logic [31:0]                                 i_addr,
  input  logic                                        i_rd,
  input  logic                                        i_wr,
  input  pmp_pkg::pmp_cfg_t  [pmp_pkg::PMP_ENTRIES-1:0] i_cfg,
  input  pmp_pkg::pmp_addr_t [pmp_pkg::PMP_ENTRIES-1:0] i_pmp_addr,
  input  pmp_pkg::priv_e                              i_priv,
  input  logic                                        i_mprv,
  input  pmp_pkg::priv_e                              i_mpp,
  output logic                                        o_fault
);

  logic [pmp_pkg::PMP_ENTRIES-1:0] match;
  pmp_pkg::pmp_addr_t word_addr;
  pmp_pkg::pmp_cfg_t  hit_cfg;
  logic               hit;
  pmp_pkg::priv_e     eff_priv;
  logic               rd_ok;
  logic               perm_bad;

  assign word_addr = {2'b00, i_addr[31:2]};

  for (genvar e = 0; e < pmp_pkg::PMP_ENTRIES; e++) begin : g_match
    pmp_matcher #(
      .PMP_GRAN(PMP_GRAN)
    ) matcher_inst (
      .i_word_addr (word_addr),
      .i_cfg       (i_cfg[e]),
      .i_addr      (i_pmp_addr[e]),
      .i_prev_addr ((e == 0) ? pmp_pkg::pmp_addr_t'(0) : i_pmp_addr[(e == 0) ? 0 : e-1]),
      .o_match     (match[e])
    );
  end

  // Scan from the top so the lowest matching entry is the last one taken
  always_comb begin
    hit     = 1'b0;
    hit_cfg = '0;
    for (int e = pmp_pkg::PMP_ENTRIES - 1; e >= 0; e--) begin
      if (match[e]) begin
        hit     = 1'b1;
        hit_cfg = i_cfg[e];
      end
    end
  end

  // MPRV only redirects loads and stores
  assign eff_priv = (IS_DATA && i_mprv) ? i_mpp : i_priv;

  assign rd_ok    = IS_DATA ? hit_cfg.r : hit_cfg.x;  // Fetch port checks X on i_rd
  assign perm_bad = (i_rd && !rd_ok) || (i_wr && !hit_cfg.w);

  always_comb begin
    o_fault = 1'b0;
    if (i_rd || i_wr) begin  // No request, no fault
      if (eff_priv != pmp_pkg::M) o_fault = !hit || perm_bad;
      else o_fault = hit && hit_cfg.lock && perm_bad;  // M mode bound only by locked entries
    end
  end

endmodule

// File: design/pmp_matcher.sv
// PMP entry matcher: OFF, TOR, NA4 and NAPOT address comparison for one entry
`timescale 1ns/1ns

module pmp_matcher #(
  parameter int PMP_GRAN = 0
) (
  input  pmp_pkg::pmp_addr_t i_word_addr,
  input  pmp_pkg::pmp_cfg_t  i_cfg,
  input  pmp_pkg::pmp_addr_t i_addr,
  input  pmp_pkg::pmp_addr_t i_prev_addr,
  output logic               o_match
);

  localparam pmp_pkg::pmp_addr_t GRAN_MASK = (32'd1 << PMP_GRAN) - 32'd1;

  pmp_pkg::pmp_addr_t napot_mask;
  pmp_pkg::pmp_addr_t word_g;
  pmp_pkg::pmp_addr_t lo_g;
  pmp_pkg::pmp_addr_t hi_g;

  // x ^ (x+1) sets the k trailing ones plus the zero above them
  assign napot_mask = ~(i_addr ^ (i_addr + 32'd1)) & ~GRAN_MASK;

  assign word_g = i_word_addr & ~GRAN_MASK;  // TOR bounds at granule size
  assign lo_g   = i_prev_addr & ~GRAN_MASK;
  assign hi_g   = i_addr & ~GRAN_MASK;

  always_comb begin
    case (i_cfg.amode)
      pmp_pkg::TOR:   o_match = (word_g >= lo_g) && (word_g < hi_g);
      pmp_pkg::NA4:   o_match = i_word_addr == i_addr;
      pmp_pkg::NAPOT: o_match = (i_word_addr & napot_mask) == (i_addr & napot_mask);
      default:        o_match = 1'b0;  // OFF
    endcase
  end

endmodule

// File: design/pmp_regfile.sv
// PMP register file: pmpcfg and pmpaddr storage, write legalisation, lock rules and read mux
`timescale 1ns/1ns

module pmp_regfile #(
  parameter int PMP_GRAN = 0
) (
  input  logic                                        CLK,
  input  logic                                        nRST,
  input  pmp_pkg::pmp_csr_req_t                       i_csr_req,
  output pmp_pkg::pmp_csr_rsp_t                       o_csr_rsp,
  output pmp_pkg::pmp_cfg_t  [pmp_pkg::PMP_ENTRIES-1:0] o_cfg,
  output pmp_pkg::pmp_addr_t [pmp_pkg::PMP_ENTRIES-1:0] o_addr
);

  localparam pmp_pkg::pmp_addr_t GRAN_MASK = (32'd1 << PMP_GRAN) - 32'd1;
  localparam pmp_pkg::pmp_addr_t GRAN_FILL = GRAN_MASK >> 1;  // Ones below bit G-1

  pmp_pkg::pmp_cfg_t  [pmp_pkg::PMP_ENTRIES-1:0] cfg_q;
  pmp_pkg::pmp_cfg_t  [pmp_pkg::PMP_ENTRIES-1:0] cfg_d;
  pmp_pkg::pmp_addr_t [pmp_pkg::PMP_ENTRIES-1:0] addr_q;
  pmp_pkg::pmp_addr_t [pmp_pkg::PMP_ENTRIES-1:0] addr_d;
  logic       bad_index;
  logic       wr_en;
  logic [3:0] idx_next;
  logic       addr_locked;

  function automatic pmp_pkg::pmp_cfg_t legalise_cfg(input logic [7:0] raw);
    pmp_pkg::pmp_cfg_t cfg;
    cfg = pmp_pkg::pmp_cfg_t'(raw);
    cfg.reserved = 2'b00;
    if (!cfg.r) cfg.w = 1'b0;  // W without R is reserved
    if (PMP_GRAN > 0 && cfg.amode == pmp_pkg::NA4) cfg.amode = pmp_pkg::NAPOT;
    return cfg;
  endfunction

  // Coarse granularity forces the smallest NAPOT region when low bits are not all ones
  function automatic pmp_pkg::pmp_addr_t legalise_addr(input pmp_pkg::pmp_word_t raw);
    if (PMP_GRAN > 0 && (raw & GRAN_MASK) != GRAN_MASK) return (raw & ~GRAN_MASK) | GRAN_FILL;
    return raw;
  endfunction

  assign bad_index = !i_csr_req.is_addr && (i_csr_req.index[3:2] != 2'b00);
  assign wr_en     = i_csr_req.valid && i_csr_req.wr && !bad_index;

  // TOR in entry i+1 also uses pmpaddr i as its base
  assign idx_next    = i_csr_req.index + 4'd1;
  assign addr_locked = cfg_q[i_csr_req.index].lock ||
                       ((i_csr_req.index != 4'd15) &&
                        (cfg_q[idx_next].amode == pmp_pkg::TOR) && cfg_q[idx_next].lock);

  always_comb begin
    cfg_d  = cfg_q;
    addr_d = addr_q;
    if (wr_en && !i_csr_req.is_addr) begin
      for (int b = 0; b < 4; b++) begin
        if (!cfg_q[{i_csr_req.index[1:0], 2'(b)}].lock) begin  // Locked bytes keep old value
          cfg_d[{i_csr_req.index[1:0], 2'(b)}] = legalise_cfg(i_csr_req.data[8*b +: 8]);
        end
      end
    end
    if (wr_en && i_csr_req.is_addr && !addr_locked) begin
      addr_d[i_csr_req.index] = legalise_addr(i_csr_req.data);
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cfg_q  <= '0;
      addr_q <= '0;
    end else begin
      cfg_q  <= cfg_d;
      addr_q <= addr_d;
    end
  end

  always_comb begin
    o_csr_rsp.err = bad_index;
    if (i_csr_req.is_addr) begin
      o_csr_rsp.data = addr_q[i_csr_req.index];
    end else if (bad_index) begin
      o_csr_rsp.data = '0;
    end else begin
      o_csr_rsp.data = {cfg_q[{i_csr_req.index[1:0], 2'd3}],
                        cfg_q[{i_csr_req.index[1:0], 2'd2}],
                        cfg_q[{i_csr_req.index[1:0], 2'd1}],
                        cfg_q[{i_csr_req.index[1:0], 2'd0}]};
    end
  end

  assign o_cfg  = cfg_q;
  assign o_addr = addr_q;

  for (genvar e = 0; e < pmp_pkg::PMP_ENTRIES; e++) begin : g_lock_chk
    a_lock_hold: assert property (@(posedge CLK) disable iff (!nRST)
      cfg_q[e].lock |=> $stable(cfg_q[e]));
  end

endmodule

// File: design/pmp_csr_axil.sv
// AXI4-Lite slave for the PMP registers: handshake FSM, offset decode and held responses
`timescale 1ns/1ns

module pmp_csr_axil (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic [31:0]            i_awaddr,
  input  logic                   i_awvalid,
  output logic                   o_awready,
  input  logic [31:0]            i_wdata,
  input  logic [3:0]             i_wstrb,
  input  logic                   i_wvalid,
  output logic                   o_wready,
  output logic [1:0]             o_bresp,
  output logic                   o_bvalid,
  input  logic                   i_bready,
  input  logic [31:0]            i_araddr,
  input  logic                   i_arvalid,
  output logic                   o_arready,
  output logic [31:0]            o_rdata,
  output logic [1:0]             o_rresp,
  output logic                   o_rvalid,
  input  logic                   i_rready,
  output pmp_pkg::pmp_csr_req_t  o_csr_req,
  input  pmp_pkg::pmp_csr_rsp_t  i_csr_rsp
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {ST_IDLE, ST_WRESP, ST_RRESP} axil_state_e;

  axil_state_e state_q;
  axil_state_e state_d;
  logic        wr_go;
  logic        rd_go;
  logic [31:0] req_addr;
  logic        cfg_hit;
  logic        addr_hit;
  logic        req_ok;
  logic        resp_err;
  logic [1:0]  bresp_q;
  logic [1:0]  rresp_q;
  logic [31:0] rdata_q;

  // Write needs AW and W together and wins over a read in the same cycle
  assign wr_go = (state_q == ST_IDLE) && i_awvalid && i_wvalid;
  assign rd_go = (state_q == ST_IDLE) && i_arvalid && !(i_awvalid && i_wvalid);

  assign o_awready = wr_go;
  assign o_wready  = wr_go;
  assign o_arready = rd_go;

  assign req_addr = wr_go ? i_awaddr : i_araddr;
  assign cfg_hit  = (req_addr & ~32'h0000_000C) == pmp_pkg::CFG_BASE;  // Word aligned only
  assign addr_hit = (req_addr & ~32'h0000_003C) == pmp_pkg::ADDR_BASE;
  assign req_ok   = (cfg_hit || addr_hit) && (!wr_go || (&i_wstrb));  // Partial strobes refused

  always_comb begin
    o_csr_req.wr      = wr_go;
    o_csr_req.is_addr = addr_hit;
    o_csr_req.index   = addr_hit ? req_addr[5:2] : {2'b00, req_addr[3:2]};
    o_csr_req.data    = i_wdata;
    o_csr_req.valid   = (wr_go || rd_go) && req_ok;
  end

  assign resp_err = !req_ok || i_csr_rsp.err;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (wr_go) state_d = ST_WRESP;
        else if (rd_go) state_d = ST_RRESP;
      end
      ST_WRESP: if (i_bready) state_d = ST_IDLE;
      ST_RRESP: if (i_rready) state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) state_q <= ST_IDLE;
    else state_q <= state_d;
  end

  // Response payload captured at acceptance, held while the state waits for ready
  always_ff @(posedge CLK) begin
    if (wr_go) bresp_q <= resp_err ? RESP_SLVERR : RESP_OKAY;
    if (rd_go) begin
      rresp_q <= resp_err ? RESP_SLVERR : RESP_OKAY;
      rdata_q <= resp_err ? 32'd0 : i_csr_rsp.data;
    end
  end

  assign o_bvalid = state_q == ST_WRESP;
  assign o_bresp  = bresp_q;
  assign o_rvalid = state_q == ST_RRESP;
  assign o_rresp  = rresp_q;
  assign o_rdata  = rdata_q;

  a_b_hold: assert property (@(posedge CLK) disable iff (!nRST)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

endmodule

// File: design/pmp_pkg.sv
// PMP shared types: entry config, address and word vectors, privilege enum, bus and access structs
package pmp_pkg;

  localparam int PMP_ENTRIES = 16;

  typedef logic [31:0] pmp_addr_t;  // Physical address bits 33..2
  typedef logic [31:0] pmp_word_t;  // Bus data word

  // Register map, byte offsets
  localparam pmp_word_t CFG_BASE  = 32'h0000_0000;  // pmpcfg0..3 at 0x00..0x0C
  localparam pmp_word_t ADDR_BASE = 32'h0000_0040;  // pmpaddr0..15 at 0x40..0x7C

  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } pmp_amode_e;

  typedef enum logic [1:0] {
    U = 2'd0,
    S = 2'd1,
    M = 2'd3
  } priv_e;

  // One configuration byte, L at bit 7 down to R at bit 0
  typedef struct packed {
    logic       lock;
    logic [1:0] reserved;
    pmp_amode_e amode;
    logic       x;
    logic       w;
    logic       r;
  } pmp_cfg_t;

  typedef struct packed {
    logic       wr;       // Write, else read
    logic       is_addr;  // pmpaddr, else pmpcfg
    logic [3:0] index;
    pmp_word_t  data;
    logic       valid;
  } pmp_csr_req_t;

  typedef struct packed {
    pmp_word_t data;
    logic      err;
  } pmp_csr_rsp_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] daddr;
    logic [31:0] iaddr;
    logic        ren;
    logic        wen;
    logic        xen;
    priv_e       priv;
    logic        mprv;
    priv_e       mpp;
  } pmp_access_t;

  typedef struct packed {
    logic valid;
    logic s_fault;
    logic l_fault;
    logic i_fault;
  } pmp_fault_t;

endpackage
